// File: all.f
source/fetch_pkg.sv
source/pre_decode.sv
source/fetch_queue.sv
source/fetch_pipeline.sv
source/inst_compact.sv
source/fetch_top.sv
verif/fetch_properties.sv
verif/fetch_tb.sv

// File: run.sh
#!/bin/bash
# build and run the fetch stage simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f all.f -o fetch_sim &&
./obj_dir/fetch_sim | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// File: verif/fetch_tests.mem
// words 0-15: 64 byte instruction image, little endian words
// then one test per line: name start_addr next_addr flags
// flags: [3:0] size, [4] taken, [8] redirect expected, [12] random stall, [16] squash first
00108093
00010001
00108093
0080006f
00108093
0001a011
00000463
00108093
00010001
00010001
00010001
00010001
00010001
00010001
00010001
00010001
00000001 00000000 00000008 00000008
00000002 00000008 00000014 0000001c
00000003 00000008 00000020 0000011c
00000004 00000020 00000040 00000118
00000005 00000005 00000009 00000004
00000006 00000018 00000020 00001008
00000007 00000010 00000018 00001018
00000008 00000000 00000008 00011008
00000009 00000004 0000000c 00001008
0000000a 00000024 0000002a 00001006
0000000b 00000010 00000040 00000118
00000000 00000000 00000000 00000000

// File: verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               i_pred_vld;
    fetch_pkg::fetch_block_t            i_pred_block;
    logic                               o_ftq_full;
    logic                               o_icache_req;
    fetch_pkg::addr_t                   o_icache_addr;
    logic                               i_icache_vld;
    logic [fetch_pkg::LINE_BYTES*8-1:0] i_icache_data;
    logic                               i_squash_vld;
    logic                               i_stall;
    logic [fetch_pkg::OUT_WIDTH-1:0]    o_inst_vld;
    fetch_pkg::fetch_inst_t             o_inst [fetch_pkg::OUT_WIDTH];
    logic                               o_redirect_vld;
    fetch_pkg::addr_t                   o_redirect_pc;

    // image in words 0-15 and tests from word 16
    logic [31:0] tests [0:127];

    logic [31:0]         lfsr;
    int                  errors;
    int                  n_tests;
    int                  test_name;
    logic                req_pend;
    fetch_pkg::addr_t    req_addr;
    logic                stall_en;
    fetch_pkg::ftq_idx_t wr_idx;

    // expected results of the running test
    int                  exp_cnt;
    fetch_pkg::inst_t    exp_inst [4];
    fetch_pkg::addr_t    exp_pc [4];
    fetch_pkg::slot_idx_t exp_off [4];
    logic                exp_mis;
    fetch_pkg::ftq_idx_t exp_idx;
    logic                exp_redir;
    fetch_pkg::addr_t    exp_redir_pc;
    int                  got_bundles;
    int                  got_redirs;

    always #20 clk = ~clk;

    fetch_top #(
        .FTQ_DEPTH ( 4 )
    ) u_dut (
        .clk            ( clk            ),
        .rst            ( rst            ),
        .i_pred_vld     ( i_pred_vld     ),
        .i_pred_block   ( i_pred_block   ),
        .o_ftq_full     ( o_ftq_full     ),
        .o_icache_req   ( o_icache_req   ),
        .o_icache_addr  ( o_icache_addr  ),
        .i_icache_vld   ( i_icache_vld   ),
        .i_icache_data  ( i_icache_data  ),
        .i_squash_vld   ( i_squash_vld   ),
        .i_stall        ( i_stall        ),
        .o_inst_vld     ( o_inst_vld     ),
        .o_inst         ( o_inst         ),
        .o_redirect_vld ( o_redirect_vld ),
        .o_redirect_pc  ( o_redirect_pc  )
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] img_byte(input fetch_pkg::addr_t a);
        logic [31:0] word;
        word = tests[a[5:2]];
        return word[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [255:0] line_of(input fetch_pkg::addr_t base);
        logic [255:0] line;
        for (int i = 0; i < 32; i++) begin
            line[i*8 +: 8] = img_byte(base + fetch_pkg::addr_t'(i));
        end
        return line;
    endfunction

    // halfword k of the window with zeros past the end of the line
    function automatic logic [15:0] win_half(input fetch_pkg::addr_t start, input int k);
        int               off;
        fetch_pkg::addr_t base;
        logic [7:0]       b0;
        logic [7:0]       b1;
        off  = int'(start[4:0]) + 2 * k;
        base = {start[31:5], 5'b0};
        b0   = (off < 32) ? img_byte(base + fetch_pkg::addr_t'(off)) : 8'h00;
        b1   = (off + 1 < 32) ? img_byte(base + fetch_pkg::addr_t'(off + 1)) : 8'h00;
        return {b1, b0};
    endfunction

    // kind 0 plain, 1 direct jump, 2 conditional, 3 indirect
    function automatic fetch_pkg::addr_t decode_ref(input fetch_pkg::inst_t i,
                                                    input fetch_pkg::addr_t pc,
                                                    output int kind);
        kind = 0;
        if (i[6:0] == 7'h6f) begin
            kind = 1;
            return pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        end
        if (i[6:0] == 7'h67) begin
            kind = 3;
            return '0;
        end
        if (i[6:0] == 7'h63) begin
            kind = 2;
            return pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        end
        if (i[1:0] == 2'b01 && i[15:13] == 3'b101) begin
            kind = 1;
            return pc + {{21{i[12]}}, i[8], i[10:9], i[6], i[7], i[2], i[11], i[5:3], 1'b0};
        end
        if (i[1:0] == 2'b01 && i[15:14] == 2'b11) begin
            kind = 2;
            return pc + {{24{i[12]}}, i[6:5], i[2], i[11:10], i[4:3], 1'b0};
        end
        if (i[1:0] == 2'b10 && i[15:12] == 4'b1000 && i[11:7] != 0 && i[6:2] == 0) begin
            kind = 3;
        end
        return '0;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        $display("FAILED test %0d %s expected %h actual %h", test_name, what, exp_v, act_v);
        errors++;
    endtask

    task automatic report_text(input string msg);
        $display("test %0d error: %s", test_name, msg);
        errors++;
    endtask

    task automatic build_expected(input fetch_pkg::fetch_block_t blk);
        int               k;
        int               lim;
        int               kind;
        int               last_kind;
        logic             model_redir;
        fetch_pkg::addr_t tgt;
        fetch_pkg::addr_t last_tgt;
        fetch_pkg::addr_t fall;
        fetch_pkg::inst_t ins;
        exp_cnt   = 0;
        exp_mis   = blk.start_addr[0];
        last_kind = 0;
        last_tgt  = '0;
        fall      = '0;
        lim       = (blk.size == 0) ? 8 : int'(blk.size) / 2;
        k         = 0;
        while (k < lim && exp_cnt < 4) begin
            ins = {win_half(blk.start_addr, k + 1), win_half(blk.start_addr, k)};
            tgt = decode_ref(ins, blk.start_addr + fetch_pkg::addr_t'(2 * k), kind);
            exp_inst[exp_cnt] = ins;
            exp_pc[exp_cnt]   = blk.start_addr + fetch_pkg::addr_t'(2 * k);
            exp_off[exp_cnt]  = fetch_pkg::slot_idx_t'(k);
            exp_cnt++;
            last_kind = kind;
            last_tgt  = tgt;
            fall = blk.start_addr + fetch_pkg::addr_t'(2 * k + ((ins[1:0] == 2'b11) ? 4 : 2));
            if (exp_mis || kind == 1 || kind == 3) begin
                break;
            end
            k += (ins[1:0] == 2'b11) ? 2 : 1;
        end
        case (last_kind)
            1: model_redir = (last_tgt != blk.next_addr);
            2: model_redir = (last_tgt != blk.next_addr) && (fall != blk.next_addr);
            3: model_redir = 1'b0;
            default: model_redir = (fall != blk.next_addr);
        endcase
        if (exp_mis) begin
            model_redir = 1'b0;
        end
        exp_redir_pc = (last_kind == 1) ? last_tgt : fall;
        assert (model_redir == exp_redir)
            else report_text("test data and reference model disagree on the redirect");
    endtask

    task automatic observe();
        logic [3:0] mask;
        mask = (4'b1 << exp_cnt) - 4'b1;
        // the queue never holds more than two of its four blocks
        assert (!o_ftq_full)
            else report_text("queue reported full while holding at most two blocks");
        if (o_redirect_vld) begin
            got_redirs++;
            wr_idx = '0;
            assert (exp_redir && got_redirs == 1)
                else report_text("redirect raised when none was expected");
            assert (o_redirect_pc == exp_redir_pc)
                else report_value("redirect pc", exp_redir_pc, o_redirect_pc);
        end
        if ((|o_inst_vld) && !i_stall) begin
            got_bundles++;
            assert (got_bundles == 1) else report_text("more than one bundle delivered");
            assert (o_inst_vld == mask) else report_value("valid mask", 32'(mask), 32'(o_inst_vld));
            for (int j = 0; j < exp_cnt; j++) begin
                assert (o_inst[j].inst == exp_inst[j])
                    else report_value("inst", exp_inst[j], o_inst[j].inst);
                assert (o_inst[j].pc == exp_pc[j])
                    else report_value("pc", exp_pc[j], o_inst[j].pc);
                assert (o_inst[j].ftq_idx == exp_idx)
                    else report_value("ftq index", 32'(exp_idx), 32'(o_inst[j].ftq_idx));
                assert (o_inst[j].offset == exp_off[j])
                    else report_value("slot offset", 32'(exp_off[j]), 32'(o_inst[j].offset));
                assert (o_inst[j].misaligned == exp_mis)
                    else report_value("misaligned", 32'(exp_mis), 32'(o_inst[j].misaligned));
            end
        end
    endtask

    // one clock of stimulus and checks
    task automatic cycle(input logic push, input fetch_pkg::fetch_block_t blk,
                         input logic squash);
        fetch_pkg::addr_t line_addr;
        line_addr = {blk.start_addr[31:5], 5'b00000};
        @(negedge clk);
        // the stall level set here decides whether the shown bundle is taken
        if (stall_en) begin
            lfsr    = lfsr_next(lfsr);
            i_stall = lfsr[0];
        end else begin
            i_stall = 1'b0;
        end
        observe();
        i_icache_vld  = req_pend;
        i_icache_data = req_pend ? line_of(req_addr) : '0;
        i_pred_vld   = push;
        i_pred_block = blk;
        i_squash_vld = squash;
        if (push) begin
            wr_idx++;
        end
        if (squash) begin
            wr_idx = '0;
        end
        #1;
        req_pend = o_icache_req;
        req_addr = o_icache_addr;
        if (o_icache_req) begin
            assert (o_icache_addr == line_addr)
                else report_value("cache address", line_addr, o_icache_addr);
        end
    endtask

    task automatic run_test(input int base);
        fetch_pkg::fetch_block_t blk;
        logic [31:0]             flags;
        int                      cyc;
        test_name       = tests[base];
        blk.start_addr  = tests[base + 1];
        blk.next_addr   = tests[base + 2];
        flags           = tests[base + 3];
        blk.size        = flags[3:0];
        blk.taken       = flags[4];
        exp_redir       = flags[8];
        stall_en        = flags[12];
        got_bundles     = 0;
        got_redirs      = 0;
        build_expected(blk);
        if (flags[16]) begin
            // this block must be dropped by the squash
            cycle(1'b1, blk, 1'b0);
            cycle(1'b0, blk, 1'b1);
        end
        exp_idx = wr_idx;
        cycle(1'b1, blk, 1'b0);
        if (exp_redir) begin
            // queued behind the mispredicted block and lost on redirect
            cycle(1'b1, blk, 1'b0);
        end
        cyc = 0;
        while (!(got_bundles > 0 && (got_redirs > 0 || !exp_redir)) && cyc < 200) begin
            cycle(1'b0, blk, 1'b0);
            cyc++;
        end
        assert (cyc < 200) else report_text("timeout waiting for the bundle or redirect");
        stall_en = 1'b0;
        for (int i = 0; i < 10; i++) begin
            cycle(1'b0, blk, 1'b0);
        end
        $display("test %0d done, %0d errors so far", test_name, errors);
    endtask

    initial begin
        int base;
        rst           = 1'b1;
        i_pred_vld    = 1'b0;
        i_pred_block  = '0;
        i_icache_vld  = 1'b0;
        i_icache_data = '0;
        i_squash_vld  = 1'b0;
        i_stall       = 1'b0;
        lfsr          = 32'h96fa82d5;
        errors        = 0;
        n_tests       = 0;
        test_name     = 0;
        req_pend      = 1'b0;
        req_addr      = '0;
        stall_en      = 1'b0;
        wr_idx        = '0;
        exp_cnt       = 0;
        exp_redir     = 1'b0;
        $readmemh("verif/fetch_tests.mem", tests);
        repeat (3) @(negedge clk);
        rst  = 1'b0;
        base = 16;
        while (base < 124 && tests[base] != 0) begin
            run_test(base);
            n_tests++;
            base += 4;
        end
        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fetch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_properties (
    input logic                          clk,
    input logic                          rst,
    input logic                          i_flush,
    input logic                          i_req,
    input logic                          i_rsp,
    input logic                          i_stall,
    input logic [fetch_pkg::OUT_WIDTH-1:0] i_inst_vld,
    input fetch_pkg::fetch_inst_t        i_inst0
);

    // cache answers exactly one cycle after the request
    assert property (@(posedge clk) disable iff (rst) i_req |=> i_rsp)
        else $error("cache response missing one cycle after request");

    assert property (@(posedge clk) disable iff (rst) i_rsp |-> $past(i_req))
        else $error("cache response without a request");

    // held bundle under stall
    assert property (@(posedge clk) disable iff (rst)
        (i_stall && (|i_inst_vld) && !i_flush) |=> ($stable(i_inst_vld) && $stable(i_inst0)))
        else $error("output bundle changed while stalled");

    assert property (@(posedge clk) disable iff (rst) i_flush |=> (i_inst_vld == '0))
        else $error("output valid in the cycle after a flush");

endmodule

bind fetch_top fetch_properties u_fetch_properties (
    .clk        ( clk            ),
    .rst        ( rst            ),
    .i_flush    ( flush          ),
    .i_req      ( o_icache_req   ),
    .i_rsp      ( i_icache_vld   ),
    .i_stall    ( i_stall        ),
    .i_inst_vld ( o_inst_vld     ),
    .i_inst0    ( o_inst[0]      )
);

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int FTQ_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,

    // branch predictor push
    input  logic                                i_pred_vld,
    input  fetch_pkg::fetch_block_t             i_pred_block,
    output logic                                o_ftq_full,

    // instruction cache
    output logic                                o_icache_req,
    output fetch_pkg::addr_t                    o_icache_addr,
    input  logic                                i_icache_vld,
    input  logic [fetch_pkg::LINE_BYTES*8-1:0]  i_icache_data,

    // backend
    input  logic                                i_squash_vld,
    input  logic                                i_stall,
    output logic [fetch_pkg::OUT_WIDTH-1:0]     o_inst_vld,
    output fetch_pkg::fetch_inst_t              o_inst [fetch_pkg::OUT_WIDTH],
    output logic                                o_redirect_vld,
    output fetch_pkg::addr_t                    o_redirect_pc
);

    logic                        flush;
    logic                        issue_vld;
    fetch_pkg::fetch_block_t     issue_block;
    fetch_pkg::ftq_idx_t         issue_idx;
    logic                        s1_free;
    logic                        issue_done;
    logic [fetch_pkg::SLOTS-1:0] slot_vld;
    fetch_pkg::inst_t            slot_inst [fetch_pkg::SLOTS];
    fetch_pkg::addr_t            slot_pc [fetch_pkg::SLOTS];
    fetch_pkg::ftq_idx_t         slot_idx;
    logic                        misaligned;
    logic                        falsepred;
    logic                        out_busy;

    // backend squash or our own false prediction
    assign flush = i_squash_vld || falsepred;

    assign o_icache_req   = issue_vld;
    assign o_icache_addr  = issue_block.start_addr &
                            ~fetch_pkg::addr_t'(fetch_pkg::LINE_BYTES - 1);
    assign o_redirect_vld = falsepred;

    fetch_queue #(
        .FTQ_DEPTH ( FTQ_DEPTH )
    ) u_fetch_queue (
        .clk           ( clk          ),
        .rst           ( rst          ),
        .i_flush       ( flush        ),
        .i_push        ( i_pred_vld   ),
        .i_block       ( i_pred_block ),
        .o_full        ( o_ftq_full   ),
        .i_s1_free     ( s1_free      ),
        .i_issue_done  ( issue_done   ),
        .o_issue_vld   ( issue_vld    ),
        .o_issue_block ( issue_block  ),
        .o_issue_idx   ( issue_idx    )
    );

    fetch_pipeline u_fetch_pipeline (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .i_flush       ( flush         ),
        .i_issue_vld   ( issue_vld     ),
        .i_issue_block ( issue_block   ),
        .i_issue_idx   ( issue_idx     ),
        .i_icache_vld  ( i_icache_vld  ),
        .i_icache_data ( i_icache_data ),
        .i_out_busy    ( out_busy      ),
        .o_s1_free     ( s1_free       ),
        .o_issue_done  ( issue_done    ),
        .o_slot_vld    ( slot_vld      ),
        .o_slot_inst   ( slot_inst     ),
        .o_slot_pc     ( slot_pc       ),
        .o_slot_idx    ( slot_idx      ),
        .o_misaligned  ( misaligned    ),
        .o_falsepred   ( falsepred     ),
        .o_redirect_pc ( o_redirect_pc )
    );

    inst_compact u_inst_compact (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .i_flush      ( flush      ),
        .i_stall      ( i_stall    ),
        .i_slot_vld   ( slot_vld   ),
        .i_slot_inst  ( slot_inst  ),
        .i_slot_pc    ( slot_pc    ),
        .i_slot_idx   ( slot_idx   ),
        .i_misaligned ( misaligned ),
        .o_busy       ( out_busy   ),
        .o_inst_vld   ( o_inst_vld ),
        .o_inst       ( o_inst     )
    );

endmodule

`default_nettype wire

// File: source/inst_compact.sv
`timescale 1ns/1ps
`default_nettype none

module inst_compact (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_flush,
    input  logic                          i_stall,

    input  logic [fetch_pkg::SLOTS-1:0]   i_slot_vld,
    input  fetch_pkg::inst_t              i_slot_inst [fetch_pkg::SLOTS],
    input  fetch_pkg::addr_t              i_slot_pc [fetch_pkg::SLOTS],
    input  fetch_pkg::ftq_idx_t           i_slot_idx,
    input  logic                          i_misaligned,

    output logic                          o_busy,
    output logic [fetch_pkg::OUT_WIDTH-1:0] o_inst_vld,
    output fetch_pkg::fetch_inst_t        o_inst [fetch_pkg::OUT_WIDTH]
);

    logic [fetch_pkg::OUT_WIDTH-1:0] pack_vld;
    fetch_pkg::fetch_inst_t          pack [fetch_pkg::OUT_WIDTH];

    // a held bundle blocks the next one
    assign o_busy = (|o_inst_vld) && i_stall;

    always_comb begin
        int cnt;
        cnt      = 0;
        pack_vld = '0;
        for (int j = 0; j < fetch_pkg::OUT_WIDTH; j++) begin
            pack[j] = '0;
        end
        // first valid slots in order, at most one bundle worth
        for (int k = 0; k < fetch_pkg::SLOTS; k++) begin
            if (i_slot_vld[k] && (cnt < fetch_pkg::OUT_WIDTH)) begin
                pack_vld[cnt]        = 1'b1;
                pack[cnt].inst       = i_slot_inst[k];
                pack[cnt].pc         = i_slot_pc[k];
                pack[cnt].ftq_idx    = i_slot_idx;
                pack[cnt].offset     = fetch_pkg::slot_idx_t'(k);
                pack[cnt].misaligned = i_misaligned;
                cnt                  = cnt + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            o_inst_vld <= '0;
        end else if (!o_busy) begin
            o_inst_vld <= pack_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_busy) begin
            o_inst <= pack;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pipeline (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_flush,

    input  logic                                i_issue_vld,
    input  fetch_pkg::fetch_block_t             i_issue_block,
    input  fetch_pkg::ftq_idx_t                 i_issue_idx,

    input  logic                                i_icache_vld,
    input  logic [fetch_pkg::LINE_BYTES*8-1:0]  i_icache_data,

    input  logic                                i_out_busy,

    output logic                                o_s1_free,
    output logic                                o_issue_done,
    output logic [fetch_pkg::SLOTS-1:0]         o_slot_vld,
    output fetch_pkg::inst_t                    o_slot_inst [fetch_pkg::SLOTS],
    output fetch_pkg::addr_t                    o_slot_pc [fetch_pkg::SLOTS],
    output fetch_pkg::ftq_idx_t                 o_slot_idx,
    output logic                                o_misaligned,
    output logic                                o_falsepred,
    output fetch_pkg::addr_t                    o_redirect_pc
);

    localparam int LINE_W = fetch_pkg::LINE_BYTES * 8;
    localparam int OFF_W  = $clog2(fetch_pkg::LINE_BYTES);

    // s1 holds the block from request until it moves to the output
    logic                    s1_vld;
    logic                    s1_has_data;
    fetch_pkg::fetch_block_t s1_block;
    fetch_pkg::ftq_idx_t     s1_idx;
    logic [LINE_W-1:0]       s1_line;

    logic [LINE_W-1:0] cur_line;
    logic [LINE_W-1:0] window;
    logic              leave;
    logic              misaligned;
    logic [3:0]        slot_limit;

    fetch_pkg::predec_t info [fetch_pkg::SLOTS];
    logic [fetch_pkg::SLOTS-1:0] starts;
    logic [fetch_pkg::SLOTS-1:0] in_size;
    logic [fetch_pkg::SLOTS-1:0] before_jump;
    logic [fetch_pkg::SLOTS-1:0] inst_vld;

    fetch_pkg::predec_t last_info;
    fetch_pkg::addr_t   last_pc;
    fetch_pkg::addr_t   fallthru;
    logic               next_ok;
    logic               falsepred_r;
    fetch_pkg::addr_t   redirect_pc_r;

    // response is used straight away unless the output was busy
    assign cur_line   = s1_has_data ? s1_line : i_icache_data;
    assign window     = cur_line >> {s1_block.start_addr[OFF_W-1:0], 3'b000};
    assign misaligned = s1_block.start_addr[0];
    assign slot_limit = (s1_block.size == '0) ? 4'd8 : {1'b0, s1_block.size[3:1]};
    assign leave      = s1_vld && (s1_has_data || i_icache_vld) && !i_out_busy;

    for (genvar k = 0; k < fetch_pkg::SLOTS; k++) begin : gen_slot
        assign o_slot_inst[k] = window[k*16 +: 32];
        assign o_slot_pc[k]   = s1_block.start_addr + fetch_pkg::addr_t'(2 * k);

        pre_decode u_pre_decode (
            .i_inst ( o_slot_inst[k] ),
            .i_pc   ( o_slot_pc[k]   ),
            .o_info ( info[k]        )
        );
    end

    always_comb begin
        starts[0]      = 1'b1;
        before_jump[0] = 1'b1;
        for (int k = 1; k < fetch_pkg::SLOTS; k++) begin
            // second half of a 32-bit instruction is no start
            starts[k]      = !(starts[k-1] && info[k-1].is_32);
            before_jump[k] = before_jump[k-1] &&
                             !(starts[k-1] && (info[k-1].is_direct || info[k-1].is_indirect));
        end
        for (int k = 0; k < fetch_pkg::SLOTS; k++) begin
            in_size[k] = (4'(k) < slot_limit);
        end
    end

    // odd start gives just slot 0, carrying the exception
    assign inst_vld = misaligned ? fetch_pkg::SLOTS'(1) : (starts & in_size & before_jump);

    always_comb begin
        last_info = info[0];
        last_pc   = o_slot_pc[0];
        for (int k = 0; k < fetch_pkg::SLOTS; k++) begin
            if (inst_vld[k]) begin
                last_info = info[k];
                last_pc   = o_slot_pc[k];
            end
        end
        fallthru = last_pc + (last_info.is_32 ? fetch_pkg::addr_t'(4) : fetch_pkg::addr_t'(2));

        if (last_info.is_direct) begin
            next_ok = (last_info.target == s1_block.next_addr);
        end else if (last_info.is_cond) begin
            next_ok = (last_info.target == s1_block.next_addr) ||
                      (fallthru == s1_block.next_addr);
        end else if (last_info.is_indirect) begin
            next_ok = 1'b1;
        end else begin
            next_ok = (fallthru == s1_block.next_addr);
        end
    end

    assign o_s1_free     = !s1_vld;
    assign o_issue_done  = leave;
    assign o_slot_vld    = leave ? inst_vld : '0;
    assign o_slot_idx    = s1_idx;
    assign o_misaligned  = misaligned;
    assign o_falsepred   = falsepred_r;
    assign o_redirect_pc = redirect_pc_r;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            s1_vld      <= 1'b0;
            s1_has_data <= 1'b0;
            falsepred_r <= 1'b0;
        end else begin
            falsepred_r <= leave && !misaligned && !next_ok;
            if (i_issue_vld) begin
                s1_vld      <= 1'b1;
                s1_has_data <= 1'b0;
            end else if (leave) begin
                s1_vld      <= 1'b0;
                s1_has_data <= 1'b0;
            end else if (s1_vld && i_icache_vld) begin
                s1_has_data <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_vld) begin
            s1_block <= i_issue_block;
            s1_idx   <= i_issue_idx;
        end
        if (s1_vld && !s1_has_data && i_icache_vld) begin
            s1_line <= i_icache_data;
        end
        if (leave) begin
            // conditional mismatch restarts at the fall-through
            redirect_pc_r <= last_info.is_direct ? last_info.target : fallthru;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int FTQ_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_flush,

    // from the branch predictor
    input  logic                   i_push,
    input  fetch_pkg::fetch_block_t i_block,
    output logic                   o_full,

    // to the cache and the pipeline
    input  logic                   i_s1_free,
    input  logic                   i_issue_done,
    output logic                   o_issue_vld,
    output fetch_pkg::fetch_block_t o_issue_block,
    output fetch_pkg::ftq_idx_t    o_issue_idx
);

    localparam int PTR_W = $clog2(FTQ_DEPTH);

    // one extra wrap bit on each pointer tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] iss_ptr;
    logic [PTR_W:0] free_ptr;

    fetch_pkg::fetch_block_t entries [FTQ_DEPTH];

    logic has_pending;
    logic push_ok;

    assign o_full = (wr_ptr[PTR_W] != free_ptr[PTR_W]) &&
                    (wr_ptr[PTR_W-1:0] == free_ptr[PTR_W-1:0]);

    assign push_ok     = i_push && !o_full;
    assign has_pending = (iss_ptr != wr_ptr);

    // head block goes out once, only while s1 can take it
    assign o_issue_vld   = has_pending && i_s1_free && !i_flush;
    assign o_issue_block = entries[iss_ptr[PTR_W-1:0]];
    assign o_issue_idx   = fetch_pkg::ftq_idx_t'(iss_ptr[PTR_W-1:0]);

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr   <= '0;
            iss_ptr  <= '0;
            free_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (o_issue_vld) begin
                iss_ptr <= iss_ptr + 1'b1;
            end
            // entry is released once its block has left s1
            if (i_issue_done) begin
                free_ptr <= free_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            entries[wr_ptr[PTR_W-1:0]] <= i_block;
        end
    end

endmodule

`default_nettype wire

// File: source/pre_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pre_decode (
    input  fetch_pkg::inst_t   i_inst,
    input  fetch_pkg::addr_t   i_pc,
    output fetch_pkg::predec_t o_info
);

    logic [6:0] opcode;
    logic [1:0] quad;
    logic [2:0] c_funct3;

    logic is_jal;
    logic is_jalr;
    logic is_br;
    logic is_cj;
    logic is_cjr;
    logic is_cbr;

    fetch_pkg::addr_t imm_j;
    fetch_pkg::addr_t imm_b;
    fetch_pkg::addr_t imm_cj;
    fetch_pkg::addr_t imm_cb;

    assign opcode   = i_inst[6:0];
    assign quad     = i_inst[1:0];
    assign c_funct3 = i_inst[15:13];

    // full size control transfers
    assign is_jal  = (opcode == 7'b1101111);
    assign is_jalr = (opcode == 7'b1100111);
    assign is_br   = (opcode == 7'b1100011);

    // compressed forms, quadrant 1 and 2
    assign is_cj  = (quad == 2'b01) && (c_funct3 == 3'b101);
    assign is_cbr = (quad == 2'b01) && (c_funct3[2:1] == 2'b11);
    // c.jr needs rs1 nonzero and rs2 zero
    assign is_cjr = (quad == 2'b10) && (i_inst[15:12] == 4'b1000) &&
                    (i_inst[11:7] != 5'd0) && (i_inst[6:2] == 5'd0);

    // sign extended pc-relative offsets
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                    i_inst[11:8], 1'b0};
    assign imm_cj = {{20{i_inst[12]}}, i_inst[12], i_inst[8], i_inst[10:9], i_inst[6],
                     i_inst[7], i_inst[2], i_inst[11], i_inst[5:3], 1'b0};
    assign imm_cb = {{23{i_inst[12]}}, i_inst[12], i_inst[6:5], i_inst[2],
                     i_inst[11:10], i_inst[4:3], 1'b0};

    always_comb begin
        o_info.is_32       = (quad == 2'b11);
        o_info.is_direct   = is_jal || is_cj;
        o_info.is_cond     = is_br || is_cbr;
        o_info.is_indirect = is_jalr || is_cjr;

        if (is_jal) begin
            o_info.target = i_pc + imm_j;
        end else if (is_br) begin
            o_info.target = i_pc + imm_b;
        end else if (is_cj) begin
            o_info.target = i_pc + imm_cj;
        end else if (is_cbr) begin
            o_info.target = i_pc + imm_cb;
        end else begin
            // indirect targets are resolved by the backend
            o_info.target = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int SLOTS      = 8;
    localparam int OUT_WIDTH  = 4;
    localparam int LINE_BYTES = 32;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [2:0]  slot_idx_t;
    typedef logic [1:0]  ftq_idx_t;
    // block size in bytes, a 16 byte block wraps to 0
    typedef logic [3:0]  blk_size_t;

    // one predicted fetch block from the branch predictor
    typedef struct packed {
        addr_t     start_addr;
        addr_t     next_addr;
        blk_size_t size;
        logic      taken;
    } fetch_block_t;

    // pre-decode result of one halfword slot
    typedef struct packed {
        logic  is_32;
        logic  is_direct;
        logic  is_cond;
        logic  is_indirect;
        addr_t target;
    } predec_t;

    // one entry of the output bundle
    typedef struct packed {
        inst_t     inst;
        addr_t     pc;
        ftq_idx_t  ftq_idx;
        // halfword slot the instruction came from
        slot_idx_t offset;
        logic      misaligned;
    } fetch_inst_t;

endpackage

`default_nettype wire
